/* design/cfg_pkg.sv */
package cfg_pkg;

    // ====================
    // Field widths
    // ====================

    // Packed configuration word
    localparam int cfg_word_w  = 32;
    // Rows per block minus one
    localparam int len_row_w   = 5;
    // Block depth and block count
    localparam int blk_w       = 4;
    // Frames per layer minus one
    localparam int frm_w       = 4;
    localparam int pool_mode_w = 2;

    // ====================
    // Word layout
    // ====================

    // Fields packed from bit 31 downward
    localparam int len_row_lsb   = cfg_word_w - len_row_w;
    localparam int dep_blk_lsb   = len_row_lsb - blk_w;
    // Blocks minus one
    localparam int num_blk_lsb   = dep_blk_lsb - blk_w;
    localparam int num_frm_lsb   = num_blk_lsb - frm_w;
    localparam int pool_en_bit   = num_frm_lsb - 1;
    localparam int pool_mode_lsb = pool_en_bit - pool_mode_w;
    // Bits below pool_mode_lsb are reserved

    // Pooling opcode
    typedef enum logic [pool_mode_w-1:0] {
        pool_none = 2'd0,
        pool_max2 = 2'd1,
        pool_max3 = 2'd2,
        pool_avg2 = 2'd3
    } pool_mode_e;

endpackage

/* design/seq_pkg.sv */
package seq_pkg;

    // Layer sequencer states
    typedef enum logic [1:0] {
        seq_idle = 2'd0,
        seq_load = 2'd1,
        seq_run  = 2'd2
    } seq_state_e;

    // ====================
    // Index widths
    // ====================

    // Same size as the matching limit fields
    localparam int row_idx_w = cfg_pkg::len_row_w;
    localparam int blk_idx_w = cfg_pkg::blk_w;
    localparam int frm_idx_w = cfg_pkg::frm_w;

endpackage

/* design/cfg_queue.sv */
`timescale 1ns/1ps

module cfg_queue #(
    parameter int queue_aw = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  logic [cfg_pkg::cfg_word_w-1:0] push_word,
    input  logic                           pop,
    output logic [cfg_pkg::cfg_word_w-1:0] head,
    output logic                           nempty,
    output logic                           full
);

    // ====================
    // Storage
    // ====================

    localparam int depth = 1 << queue_aw;

    logic [cfg_pkg::cfg_word_w-1:0] mem [depth];

    // One extra wrap bit on each pointer
    logic [queue_aw:0] wr_ptr;
    logic [queue_aw:0] rd_ptr;

    // Accepted requests only
    logic push_ok;
    logic pop_ok;

    // ====================
    // Levels
    // ====================

    // Pointers equal means empty
    assign nempty = (wr_ptr != rd_ptr);

    // Same slot but different lap means full
    assign full = (wr_ptr[queue_aw] != rd_ptr[queue_aw]) &&
                  (wr_ptr[queue_aw-1:0] == rd_ptr[queue_aw-1:0]);

    // Push when full is dropped
    assign push_ok = push && !full;
    // Pop when empty is dropped
    assign pop_ok  = pop && nempty;

    // Oldest word always on the head port
    assign head = mem[rd_ptr[queue_aw-1:0]];

    // ====================
    // Pointers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[queue_aw-1:0]] <= push_word;
        end
    end

endmodule

/* design/cfg_decode.sv */
`timescale 1ns/1ps

module cfg_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cfg_pkg::cfg_word_w-1:0] head,
    input  logic                           nempty,
    input  logic                           take,
    output logic                           pop,
    output logic                           valid,
    output logic [cfg_pkg::len_row_w-1:0]  len_row,
    output logic [cfg_pkg::blk_w-1:0]      dep_blk,
    output logic [cfg_pkg::blk_w-1:0]      num_blk,
    output logic [cfg_pkg::frm_w-1:0]      num_frm,
    output logic                           pool_en,
    output cfg_pkg::pool_mode_e            pool_mode
);

    // ====================
    // Slot control
    // ====================

    // Pull the head word whenever the slot is empty
    assign pop = nempty && !valid;

    // Sequencer take frees the slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (pop) begin
            valid <= 1'b1;
        end else if (take) begin
            valid <= 1'b0;
        end
    end

    // ====================
    // Field unpack
    // ====================

    // Captured on the pop edge
    always_ff @(posedge clk) begin
        if (pop) begin
            len_row   <= head[cfg_pkg::len_row_lsb +: cfg_pkg::len_row_w];
            dep_blk   <= head[cfg_pkg::dep_blk_lsb +: cfg_pkg::blk_w];
            num_blk   <= head[cfg_pkg::num_blk_lsb +: cfg_pkg::blk_w];
            num_frm   <= head[cfg_pkg::num_frm_lsb +: cfg_pkg::frm_w];
            pool_en   <= head[cfg_pkg::pool_en_bit];
            // Raw pooling bits into the opcode
            pool_mode <= cfg_pkg::pool_mode_e'(
                head[cfg_pkg::pool_mode_lsb +: cfg_pkg::pool_mode_w]);
        end
    end

endmodule

/* design/layer_sequencer.sv */
`timescale 1ns/1ps

module layer_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dec_valid,
    input  logic [cfg_pkg::len_row_w-1:0] len_row,
    input  logic [cfg_pkg::blk_w-1:0]     dep_blk_in,
    input  logic [cfg_pkg::blk_w-1:0]     num_blk,
    input  logic [cfg_pkg::frm_w-1:0]     num_frm,
    input  logic                          pool_en_in,
    input  cfg_pkg::pool_mode_e           pool_mode_in,
    input  logic                          pe_ready,
    output logic                          take,
    output logic                          row_strobe,
    output logic [seq_pkg::row_idx_w-1:0] row_idx,
    output logic [seq_pkg::blk_idx_w-1:0] blk_idx,
    output logic [seq_pkg::frm_idx_w-1:0] frm_idx,
    output logic                          layer_done,
    output logic                          busy,
    output logic [cfg_pkg::blk_w-1:0]     dep_blk,
    output logic                          pool_en,
    output cfg_pkg::pool_mode_e           pool_mode
);

    seq_pkg::seq_state_e state;

    // Limits of the running layer
    logic [seq_pkg::row_idx_w-1:0] lim_row;
    logic [seq_pkg::blk_idx_w-1:0] lim_blk;
    logic [seq_pkg::frm_idx_w-1:0] lim_frm;
    logic                          last_row;

    // ====================
    // Status
    // ====================

    assign take       = (state == seq_pkg::seq_load);
    assign busy       = (state != seq_pkg::seq_idle);
    // One row per ready cycle while running
    assign row_strobe = (state == seq_pkg::seq_run) && pe_ready;

    // All three counters at their limits
    assign last_row = (row_idx == lim_row) && (blk_idx == lim_blk) && (frm_idx == lim_frm);

    // ====================
    // State machine
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= seq_pkg::seq_idle;
        end else begin
            unique case (state)
                seq_pkg::seq_idle: if (dec_valid) state <= seq_pkg::seq_load;
                seq_pkg::seq_load: state <= seq_pkg::seq_run;
                seq_pkg::seq_run:  if (row_strobe && last_row) state <= seq_pkg::seq_idle;
                default:           state <= seq_pkg::seq_idle;
            endcase
        end
    end

    // Pulse in the cycle after the final row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_done <= 1'b0;
        end else begin
            layer_done <= row_strobe && last_row;
        end
    end

    // ====================
    // Layer load
    // ====================

    always_ff @(posedge clk) begin
        if (take) begin
            lim_row <= len_row;
            lim_blk <= num_blk;
            lim_frm <= num_frm;
        end
    end

    // Held for the array until the next load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dep_blk   <= '0;
            pool_en   <= 1'b0;
            pool_mode <= cfg_pkg::pool_none;
        end else if (take) begin
            dep_blk   <= dep_blk_in;
            pool_en   <= pool_en_in;
            pool_mode <= pool_mode_in;
        end
    end

    // ====================
    // Index counters
    // ====================

    // Row fastest, then block, then frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_idx <= '0;
            blk_idx <= '0;
            frm_idx <= '0;
        end else if (take) begin
            row_idx <= '0;
            blk_idx <= '0;
            frm_idx <= '0;
        end else if (row_strobe) begin
            if (row_idx != lim_row) begin
                row_idx <= row_idx + 1'b1;
            end else begin
                row_idx <= '0;
                if (blk_idx != lim_blk) begin
                    blk_idx <= blk_idx + 1'b1;
                end else begin
                    blk_idx <= '0;
                    // Wraps to zero after the last frame
                    frm_idx <= (frm_idx == lim_frm) ? '0 : frm_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* design/layer_ctrl_top.sv */
`timescale 1ns/1ps

module layer_ctrl_top #(
    parameter int queue_aw = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_val,
    input  logic [cfg_pkg::cfg_word_w-1:0] cfg_word,
    input  logic                           pe_ready,
    output logic                           cfg_full,
    output logic                           row_strobe,
    output logic [seq_pkg::row_idx_w-1:0]  row_idx,
    output logic [seq_pkg::blk_idx_w-1:0]  blk_idx,
    output logic [seq_pkg::frm_idx_w-1:0]  frm_idx,
    output logic                           layer_done,
    output logic                           busy,
    output logic [cfg_pkg::blk_w-1:0]      dep_blk,
    output logic                           pool_en,
    output cfg_pkg::pool_mode_e            pool_mode
);

    // ====================
    // Stage links
    // ====================

    // Queue to decode
    logic [cfg_pkg::cfg_word_w-1:0] q_head;
    logic                           q_nempty;
    logic                           q_pop;

    // Decode to sequencer
    logic                           dec_valid;
    logic [cfg_pkg::len_row_w-1:0]  dec_len_row;
    logic [cfg_pkg::blk_w-1:0]      dec_dep_blk;
    logic [cfg_pkg::blk_w-1:0]      dec_num_blk;
    logic [cfg_pkg::frm_w-1:0]      dec_num_frm;
    logic                           dec_pool_en;
    cfg_pkg::pool_mode_e            dec_pool_mode;
    logic                           seq_take;

    // Packed words wait here
    cfg_queue #(
        .queue_aw (queue_aw)
    ) u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cfg_val),
        .push_word (cfg_word),
        .pop       (q_pop),
        .head      (q_head),
        .nempty    (q_nempty),
        .full      (cfg_full)
    );

    // One decoded layer waiting
    cfg_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (q_head),
        .nempty    (q_nempty),
        .take      (seq_take),
        .pop       (q_pop),
        .valid     (dec_valid),
        .len_row   (dec_len_row),
        .dep_blk   (dec_dep_blk),
        .num_blk   (dec_num_blk),
        .num_frm   (dec_num_frm),
        .pool_en   (dec_pool_en),
        .pool_mode (dec_pool_mode)
    );

    // Running layer
    layer_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .len_row      (dec_len_row),
        .dep_blk_in   (dec_dep_blk),
        .num_blk      (dec_num_blk),
        .num_frm      (dec_num_frm),
        .pool_en_in   (dec_pool_en),
        .pool_mode_in (dec_pool_mode),
        .pe_ready     (pe_ready),
        .take         (seq_take),
        .row_strobe   (row_strobe),
        .row_idx      (row_idx),
        .blk_idx      (blk_idx),
        .frm_idx      (frm_idx),
        .layer_done   (layer_done),
        .busy         (busy),
        .dep_blk      (dep_blk),
        .pool_en      (pool_en),
        .pool_mode    (pool_mode)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/layer_ctrl_props.sv */
`timescale 1ns/1ps

module layer_ctrl_props (
    input logic clk,
    input logic rst_n,
    input logic layer_done,
    input logic row_strobe,
    input logic pe_ready,
    input logic busy,
    input logic cfg_full,
    input logic q_pop
);

    // Failed assertions so far
    int fail_count = 0;

    // Done is a single-cycle pulse
    a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        layer_done |=> !layer_done)
        else begin
            fail_count++;
            $error("layer_done held for more than one cycle");
        end

    // Rows only with the array ready and after a load cycle
    a_strobe_gated : assert property (@(posedge clk) disable iff (!rst_n)
        row_strobe |-> pe_ready && busy && $past(busy))
        else begin
            fail_count++;
            $error("row_strobe outside a ready, loaded layer");
        end

    // A pop always leaves room for one word
    a_pop_full : assert property (@(posedge clk) disable iff (!rst_n)
        q_pop |=> !cfg_full)
        else begin
            fail_count++;
            $error("queue still full after a pop");
        end

endmodule

bind layer_ctrl_top layer_ctrl_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .layer_done (layer_done),
    .row_strobe (row_strobe),
    .pe_ready   (pe_ready),
    .busy       (busy),
    .cfg_full   (cfg_full),
    .q_pop      (q_pop)
);

/* dv/layer_ctrl_tb.sv */
`timescale 1ns/1ps

module layer_ctrl_tb;

    logic                           clk;
    logic                           rst_n;
    logic                           cfg_val;
    logic [cfg_pkg::cfg_word_w-1:0] cfg_word;
    logic                           pe_ready;
    logic                           cfg_full;
    logic                           row_strobe;
    logic [seq_pkg::row_idx_w-1:0]  row_idx;
    logic [seq_pkg::blk_idx_w-1:0]  blk_idx;
    logic [seq_pkg::frm_idx_w-1:0]  frm_idx;
    logic                           layer_done;
    logic                           busy;
    logic [cfg_pkg::blk_w-1:0]      dep_blk;
    logic                           pool_en;
    cfg_pkg::pool_mode_e            pool_mode;

    // Scoreboard state
    logic [cfg_pkg::cfg_word_w-1:0] exp_q[$];
    logic [cfg_pkg::cfg_word_w-1:0] cur;
    logic [seq_pkg::row_idx_w-1:0]  exp_row;
    logic [seq_pkg::blk_idx_w-1:0]  exp_blk;
    logic [seq_pkg::frm_idx_w-1:0]  exp_frm;
    logic                           done_due;
    logic [15:0]                    lfsr;
    int                             budget;
    int                             cycles;

    tb_clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    layer_ctrl_top #(
        .queue_aw (2)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_val    (cfg_val),
        .cfg_word   (cfg_word),
        .pe_ready   (pe_ready),
        .cfg_full   (cfg_full),
        .row_strobe (row_strobe),
        .row_idx    (row_idx),
        .blk_idx    (blk_idx),
        .frm_idx    (frm_idx),
        .layer_done (layer_done),
        .busy       (busy),
        .dep_blk    (dep_blk),
        .pool_en    (pool_en),
        .pool_mode  (pool_mode)
    );

    // ====================
    // Helpers
    // ====================

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_idx(string name, logic [seq_pkg::row_idx_w-1:0] got,
                             logic [seq_pkg::row_idx_w-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_pool(string name, cfg_pkg::pool_mode_e got, cfg_pkg::pool_mode_e exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            stop_on_error();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Small limits keep layers short; reserved bits get noise
    function automatic logic [31:0] make_word();
        logic [31:0] w;
        w = '0;
        w[31:27] = 5'(rand_bits(2));
        w[26:23] = 4'(rand_bits(4));
        w[22:19] = 4'(rand_bits(2));
        w[18:15] = 4'(rand_bits(1));
        w[14]    = 1'(rand_bits(1));
        w[13:12] = 2'(rand_bits(2));
        w[11:0]  = 12'(rand_bits(12));
        return w;
    endfunction

    function automatic int layer_rows(logic [31:0] w);
        return (int'(w[31:27]) + 1) * (int'(w[22:19]) + 1) * (int'(w[18:15]) + 1);
    endfunction

    // One-cycle push strobe
    // Words meant to be dropped go in only while the queue is full
    task automatic push_cfg(logic [31:0] w, logic accept);
        check_bit("cfg_full", cfg_full, !accept);
        cfg_val  = 1'b1;
        cfg_word = w;
        budget   = budget + 4 * layer_rows(w) + 16;
        if (accept) begin
            exp_q.push_back(w);
        end
        @(negedge clk);
        cfg_val = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        check_bit("busy", busy, 1'b0);
    endtask

    // ====================
    // Row monitor
    // ====================

    always @(posedge clk) begin
        if (rst_n) begin
            check_bit("layer_done", layer_done, done_due);
            done_due = 1'b0;
            if (row_strobe) begin
                if (exp_q.size() == 0) begin
                    $display("Row strobe at %0t with no layer outstanding", $time);
                    stop_on_error();
                end
                cur = exp_q[0];
                check_bit("busy", busy, 1'b1);
                check_idx("row_idx", row_idx, exp_row);
                check_idx("blk_idx", blk_idx, exp_blk);
                check_idx("frm_idx", frm_idx, exp_frm);
                check_idx("dep_blk", dep_blk, cur[26:23]);
                check_bit("pool_en", pool_en, cur[14]);
                check_pool("pool_mode", pool_mode, cfg_pkg::pool_mode_e'(cur[13:12]));
                // Row fastest, then block, then frame
                if (exp_row != cur[31:27]) begin
                    exp_row = exp_row + 1'b1;
                end else begin
                    exp_row = '0;
                    if (exp_blk != cur[22:19]) begin
                        exp_blk = exp_blk + 1'b1;
                    end else begin
                        exp_blk = '0;
                        if (exp_frm != cur[18:15]) begin
                            exp_frm = exp_frm + 1'b1;
                        end else begin
                            exp_frm  = '0;
                            done_due = 1'b1;
                            void'(exp_q.pop_front());
                        end
                    end
                end
            end
        end
    end

    // Bound assertion failures end the run too
    always @(posedge clk) begin
        if (dut.u_props.fail_count != 0) begin
            $display("Bound assertion failed before %0t", $time);
            stop_on_error();
        end
    end

    // Hang guard sized from the pushed layers
    always @(posedge clk) begin
        cycles++;
        if (cycles > budget + 200) begin
            $display("Timeout after %0d cycles, the layers never finished", cycles);
            stop_on_error();
        end
    end

    // ====================
    // Tests
    // ====================

    task automatic test_reset();
        check_bit("row_strobe", row_strobe, 1'b0);
        check_bit("layer_done", layer_done, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("cfg_full", cfg_full, 1'b0);
    endtask

    task automatic test_single();
        push_cfg(make_word(), 1'b1);
        wait_drain();
    endtask

    task automatic test_queued();
        for (int n = 0; n < 4; n++) begin
            push_cfg(make_word(), 1'b1);
        end
        wait_drain();
    endtask

    task automatic test_stalls();
        push_cfg(make_word(), 1'b1);
        push_cfg(make_word(), 1'b1);
        while (exp_q.size() != 0) begin
            pe_ready = lfsr_bit();
            @(negedge clk);
        end
        pe_ready = 1'b1;
        wait_drain();
    endtask

    // Sequencer, decode slot and four queue entries fill up
    task automatic test_backpressure();
        pe_ready = 1'b0;
        for (int n = 0; n < 6; n++) begin
            push_cfg(make_word(), 1'b1);
            repeat (3) @(negedge clk);
        end
        // Dropped by the full queue
        push_cfg(make_word(), 1'b0);
        repeat (2) @(negedge clk);
        pe_ready = 1'b1;
        wait_drain();
        repeat (10) @(negedge clk);
        check_bit("busy", busy, 1'b0);
    endtask

    initial begin
        cfg_val   = 1'b0;
        cfg_word  = '0;
        pe_ready  = 1'b1;
        lfsr      = 16'd24719;
        budget    = 0;
        cycles    = 0;
        done_due  = 1'b0;
        exp_row   = '0;
        exp_blk   = '0;
        exp_frm   = '0;
        @(posedge rst_n);
        @(negedge clk);
        test_reset();
        test_single();
        test_queued();
        test_stalls();
        test_backpressure();
        if (dut.u_props.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Bound assertion failed near the end of the run");
            stop_on_error();
        end
    end

endmodule

/* build.f */
design/cfg_pkg.sv
design/seq_pkg.sv
design/cfg_queue.sv
design/cfg_decode.sv
design/layer_sequencer.sv
design/layer_ctrl_top.sv
dv/tb_clk_gen.sv
dv/layer_ctrl_props.sv
dv/layer_ctrl_tb.sv

/* Bender.yml */
package:
  name: layer_ctrl

sources:
  # Packages first
  - design/cfg_pkg.sv
  - design/seq_pkg.sv
  # RTL
  - design/cfg_queue.sv
  - design/cfg_decode.sv
  - design/layer_sequencer.sv
  - design/layer_ctrl_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/layer_ctrl_props.sv
      - dv/layer_ctrl_tb.sv
